// File: gfx_pkg.sv
// gfx register front end definitions
// address map, control bit positions, widths and the alpha word layout
`default_nettype none

package gfx_pkg;

  localparam int GFX_ADR_BITS      = 8;
  localparam logic [15:0] GFX_BASE_HI = 16'hFFD4;
  localparam int GFX_DATA_BITS     = 32;
  localparam int GFX_POINT_BITS    = 16;
  localparam int GFX_SUBPIXEL_BITS = 16;

  // command queue holds 2**GFX_FIFO_BITS entries
  localparam int GFX_FIFO_BITS     = 3;
  localparam int GFX_FIFO_CNT_BITS = GFX_FIFO_BITS + 1;

  // register offsets
  localparam logic [GFX_ADR_BITS-1:0] GFX_CONTROL       = 8'h00;
  localparam logic [GFX_ADR_BITS-1:0] GFX_STATUS        = 8'h04;
  localparam logic [GFX_ADR_BITS-1:0] GFX_ALPHA         = 8'h08;
  localparam logic [GFX_ADR_BITS-1:0] GFX_COLORKEY      = 8'h0C;
  localparam logic [GFX_ADR_BITS-1:0] GFX_TARGET_BASE   = 8'h10;
  localparam logic [GFX_ADR_BITS-1:0] GFX_TARGET_SIZE_X = 8'h14;
  localparam logic [GFX_ADR_BITS-1:0] GFX_TARGET_SIZE_Y = 8'h18;
  localparam logic [GFX_ADR_BITS-1:0] GFX_DEST_PIXEL_X  = 8'h1C;
  localparam logic [GFX_ADR_BITS-1:0] GFX_DEST_PIXEL_Y  = 8'h20;
  localparam logic [GFX_ADR_BITS-1:0] GFX_COLOR0        = 8'h24;

  // control register fields, colour depth is 3 bits wide
  localparam int GFX_CTRL_COLOR_DEPTH = 0;
  localparam int GFX_CTRL_BLENDING    = 4;
  localparam int GFX_CTRL_COLORKEY    = 5;
  localparam int GFX_CTRL_RECT        = 8;
  localparam int GFX_CTRL_LINE        = 9;
  localparam int GFX_CTRL_TRI         = 10;

  // status word, fill count in bits 31..16
  localparam int GFX_STAT_BUSY = 0;

  // alpha word, seen raw on readback or as four bytes by the blender
  typedef union packed {
    logic [GFX_DATA_BITS-1:0] raw;
    struct packed {
      logic [7:0] a0;
      logic [7:0] a1;
      logic [7:0] a2;
      logic [7:0] global_a;
    } bytes;
  } gfx_alpha_u;

endpackage

`default_nettype wire

// File: gfx_bus_slave.sv
// gfx bus slave
// window decode, registered ack/err, interrupt and read data, one enqueue per write
`timescale 1ns/1ns
`default_nettype none

module gfx_bus_slave import gfx_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      rst_i,
  input  wire  [31:0]              adr_i,
  input  wire  [GFX_DATA_BITS-1:0] dat_i,
  input  wire  [3:0]               sel_i,
  input  wire                      we_i,
  input  wire                      stb_i,
  input  wire                      cyc_i,
  input  wire                      writer_sint_i,
  input  wire                      reader_sint_i,
  input  wire                      fifo_full_i,
  input  wire  [GFX_DATA_BITS-1:0] rd_data_i,
  input  wire  [GFX_DATA_BITS-1:0] status_i,
  output logic [GFX_DATA_BITS-1:0] dat_o,
  output logic                     ack_o,
  output logic                     err_o,
  output logic                     inta_o,
  output logic                     wr_en_o,
  output logic [GFX_ADR_BITS-1:0]  wr_adr_o,
  output logic [GFX_DATA_BITS-1:0] wr_data_o,
  output logic [GFX_ADR_BITS-1:0]  rd_adr_o
);

  logic acc;
  logic acc32;
  logic reg_acc;
  logic rd_acc;

  assign acc     = cyc_i & stb_i & (adr_i[31:16] == GFX_BASE_HI);
  assign acc32   = (sel_i == 4'b1111);
  assign reg_acc = acc & acc32;

  // the ack cycle closes the access, so it also masks a second enqueue
  assign rd_acc  = reg_acc & ~we_i & ~ack_o;
  assign wr_en_o = reg_acc & we_i & ~ack_o & ~fifo_full_i;

  // word aligned register offset
  assign wr_adr_o  = {adr_i[GFX_ADR_BITS-1:2], 2'b00};
  assign rd_adr_o  = wr_adr_o;
  assign wr_data_o = dat_i;

  // a write waits here while the queue is full
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      ack_o  <= 1'b0;
      err_o  <= 1'b0;
      inta_o <= 1'b0;
    end
    else
    begin
      ack_o  <= wr_en_o | rd_acc;
      err_o  <= acc & ~acc32 & ~err_o;
      inta_o <= writer_sint_i | reader_sint_i;
    end
  end

  // status lives in the sequencer, the rest in the register file
  always_ff @(posedge clk_i)
  begin
    if (rd_acc)
    begin
      if (rd_adr_o == GFX_STATUS)
        dat_o <= status_i;
      else
        dat_o <= rd_data_i;
    end
  end

  // a single enqueue per write needs the strobe dropped after ack or err
  a_stb_drop: assert property (@(posedge clk_i) disable iff (rst_i)
    (ack_o || err_o) |=> !stb_i);

endmodule

`default_nettype wire

// File: gfx_cmd_fifo.sv
// gfx command queue
// circular buffer of register writes with a fill count
`timescale 1ns/1ns
`default_nettype none

module gfx_cmd_fifo import gfx_pkg::*;
(
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          enq_i,
  input  wire  [GFX_ADR_BITS-1:0]      adr_i,
  input  wire  [GFX_DATA_BITS-1:0]     data_i,
  input  wire                          deq_i,
  output logic                         full_o,
  output logic                         valid_o,
  output logic [GFX_ADR_BITS-1:0]      q_adr_o,
  output logic [GFX_DATA_BITS-1:0]     q_data_o,
  output logic [GFX_FIFO_CNT_BITS-1:0] count_o
);

  localparam int DEPTH = 1 << GFX_FIFO_BITS;

  logic [GFX_ADR_BITS-1:0]  adr_mem  [DEPTH];
  logic [GFX_DATA_BITS-1:0] data_mem [DEPTH];
  logic [GFX_FIFO_BITS-1:0] wr_ptr;
  logic [GFX_FIFO_BITS-1:0] rd_ptr;

  assign full_o   = (count_o == GFX_FIFO_CNT_BITS'(DEPTH));
  assign valid_o  = (count_o != '0);
  assign q_adr_o  = adr_mem[rd_ptr];
  assign q_data_o = data_mem[rd_ptr];

  always_ff @(posedge clk_i)
  begin
    if (enq_i)
    begin
      adr_mem[wr_ptr]  <= adr_i;
      data_mem[wr_ptr] <= data_i;
    end
  end

  // pointers wrap naturally at the queue depth
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end
    else
    begin
      if (enq_i)
        wr_ptr <= wr_ptr + 1'b1;
      if (deq_i)
        rd_ptr <= rd_ptr + 1'b1;
      if (enq_i && !deq_i)
        count_o <= count_o + 1'b1;
      else if (deq_i && !enq_i)
        count_o <= count_o - 1'b1;
    end
  end

  // the slave and the sequencer keep these guards
  a_no_enq_full: assert property (@(posedge clk_i) disable iff (rst_i)
    !(enq_i && full_o));
  a_no_deq_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    !(deq_i && !valid_o));

endmodule

`default_nettype wire

// File: gfx_op_sequencer.sv
// gfx operation sequencer
// wait/busy state, queue drain gate and the status word
`timescale 1ns/1ns
`default_nettype none

module gfx_op_sequencer import gfx_pkg::*;
(
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          valid_i,
  input  wire                          trigger_i,
  input  wire                          pipeline_ack_i,
  input  wire  [GFX_FIFO_CNT_BITS-1:0] count_i,
  output logic                         deq_o,
  output logic                         busy_o,
  output logic [GFX_DATA_BITS-1:0]     status_o
);

  logic                         deq_q;
  logic                         stat_busy_q;
  logic [GFX_FIFO_CNT_BITS-1:0] stat_cnt_q;

  // one entry every other cycle, never with a trigger pending
  assign deq_o = valid_i & ~busy_o & ~trigger_i & ~deq_q;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      busy_o      <= 1'b0;
      deq_q       <= 1'b0;
      stat_busy_q <= 1'b0;
      stat_cnt_q  <= '0;
    end
    else
    begin
      deq_q <= deq_o;
      if (!busy_o && trigger_i)
        busy_o <= 1'b1;
      else if (busy_o && pipeline_ack_i)
        busy_o <= 1'b0;
      stat_busy_q <= busy_o;
      stat_cnt_q  <= count_i;
    end
  end

  always_comb
  begin
    status_o                = '0;
    status_o[GFX_STAT_BUSY] = stat_busy_q;
    status_o[31:16]         = 16'(stat_cnt_q);
  end

  // a trigger seen in busy would start no operation
  a_no_trig_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    busy_o |-> !trigger_i);

endmodule

`default_nettype wire

// File: gfx_reg_file.sv
// gfx configuration registers
// loaded from the command queue, with self-clearing triggers and readback
`timescale 1ns/1ns
`default_nettype none

module gfx_reg_file import gfx_pkg::*;
(
  input  wire                                                  clk_i,
  input  wire                                                  rst_i,
  input  wire                                                  wr_en_i,
  input  wire  [GFX_ADR_BITS-1:0]                              wr_adr_i,
  input  wire  [GFX_DATA_BITS-1:0]                             wr_data_i,
  input  wire  [GFX_ADR_BITS-1:0]                              rd_adr_i,
  output logic [GFX_DATA_BITS-1:0]                             rd_data_o,
  output logic                                                 trigger_o,
  output logic                                                 rect_write_o,
  output logic                                                 line_write_o,
  output logic                                                 triangle_write_o,
  output logic [2:0]                                           color_depth_o,
  output logic                                                 blending_enable_o,
  output logic                                                 colorkey_enable_o,
  output logic [7:0]                                           a0_o,
  output logic [7:0]                                           a1_o,
  output logic [7:0]                                           a2_o,
  output logic [7:0]                                           global_alpha_o,
  output logic [GFX_DATA_BITS-1:0]                             colorkey_o,
  output logic [GFX_DATA_BITS-1:0]                             color0_o,
  output logic [GFX_DATA_BITS-1:0]                             target_base_o,
  output logic [GFX_POINT_BITS-1:0]                            target_size_x_o,
  output logic [GFX_POINT_BITS-1:0]                            target_size_y_o,
  output logic signed [GFX_POINT_BITS+GFX_SUBPIXEL_BITS-1:0]   dest_pixel_x_o,
  output logic signed [GFX_POINT_BITS+GFX_SUBPIXEL_BITS-1:0]   dest_pixel_y_o
);

  logic [GFX_DATA_BITS-1:0]        control_q;
  gfx_alpha_u                      alpha_q;
  logic [GFX_DATA_BITS-1:0]        colorkey_q;
  logic [GFX_DATA_BITS-1:0]        target_base_q;
  logic [GFX_DATA_BITS-1:0]        target_size_x_q;
  logic [GFX_DATA_BITS-1:0]        target_size_y_q;
  logic signed [GFX_DATA_BITS-1:0] dest_x_q;
  logic signed [GFX_DATA_BITS-1:0] dest_y_q;
  logic [GFX_DATA_BITS-1:0]        color0_q;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      control_q       <= '0;
      alpha_q.raw     <= '1;
      colorkey_q      <= '0;
      target_base_q   <= '0;
      target_size_x_q <= '0;
      target_size_y_q <= '0;
      dest_x_q        <= '0;
      dest_y_q        <= '0;
      color0_q        <= '0;
    end
    else if (wr_en_i)
    begin
      case (wr_adr_i)
        GFX_CONTROL:       control_q       <= wr_data_i;
        GFX_ALPHA:         alpha_q.raw     <= wr_data_i;
        GFX_COLORKEY:      colorkey_q      <= wr_data_i;
        GFX_TARGET_BASE:   target_base_q   <= wr_data_i;
        GFX_TARGET_SIZE_X: target_size_x_q <= wr_data_i;
        GFX_TARGET_SIZE_Y: target_size_y_q <= wr_data_i;
        GFX_DEST_PIXEL_X:  dest_x_q        <= $signed(wr_data_i);
        GFX_DEST_PIXEL_Y:  dest_y_q        <= $signed(wr_data_i);
        GFX_COLOR0:        color0_q        <= wr_data_i;
        default:           ;
      endcase
    end
    else
    begin
      // triggers last one cycle, the sequencer blocks a dequeue meanwhile
      control_q[GFX_CTRL_RECT] <= 1'b0;
      control_q[GFX_CTRL_LINE] <= 1'b0;
      control_q[GFX_CTRL_TRI]  <= 1'b0;
    end
  end

  // control decode
  assign color_depth_o     = control_q[GFX_CTRL_COLOR_DEPTH +: 3];
  assign blending_enable_o = control_q[GFX_CTRL_BLENDING];
  assign colorkey_enable_o = control_q[GFX_CTRL_COLORKEY];
  assign rect_write_o      = control_q[GFX_CTRL_RECT];
  assign line_write_o      = control_q[GFX_CTRL_LINE];
  assign triangle_write_o  = control_q[GFX_CTRL_TRI];
  assign trigger_o         = rect_write_o | line_write_o | triangle_write_o;

  assign a0_o           = alpha_q.bytes.a0;
  assign a1_o           = alpha_q.bytes.a1;
  assign a2_o           = alpha_q.bytes.a2;
  assign global_alpha_o = alpha_q.bytes.global_a;

  assign colorkey_o      = colorkey_q;
  assign color0_o        = color0_q;
  assign target_base_o   = target_base_q;
  assign target_size_x_o = target_size_x_q[GFX_POINT_BITS-1:0];
  assign target_size_y_o = target_size_y_q[GFX_POINT_BITS-1:0];
  assign dest_pixel_x_o  = dest_x_q;
  assign dest_pixel_y_o  = dest_y_q;

  // committed values only, unmapped offsets read zero
  always_comb
  begin
    case (rd_adr_i)
      GFX_CONTROL:       rd_data_o = control_q;
      GFX_ALPHA:         rd_data_o = alpha_q.raw;
      GFX_COLORKEY:      rd_data_o = colorkey_q;
      GFX_TARGET_BASE:   rd_data_o = target_base_q;
      GFX_TARGET_SIZE_X: rd_data_o = target_size_x_q;
      GFX_TARGET_SIZE_Y: rd_data_o = target_size_y_q;
      GFX_DEST_PIXEL_X:  rd_data_o = dest_x_q;
      GFX_DEST_PIXEL_Y:  rd_data_o = dest_y_q;
      GFX_COLOR0:        rd_data_o = color0_q;
      default:           rd_data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: gfx_wbs.sv
// gfx register front end top level
// bus slave, command queue, sequencer and register file
`timescale 1ns/1ns
`default_nettype none

module gfx_wbs import gfx_pkg::*;
(
  input  wire                                                 clk_i,
  input  wire                                                 rst_i,
  input  wire  [31:0]                                         adr_i,
  input  wire  [GFX_DATA_BITS-1:0]                            dat_i,
  output logic [GFX_DATA_BITS-1:0]                            dat_o,
  input  wire  [3:0]                                          sel_i,
  input  wire                                                 we_i,
  input  wire                                                 stb_i,
  input  wire                                                 cyc_i,
  output logic                                                ack_o,
  output logic                                                err_o,
  output logic                                                inta_o,
  input  wire                                                 writer_sint_i,
  input  wire                                                 reader_sint_i,
  input  wire                                                 pipeline_ack_i,
  output logic                                                rect_write_o,
  output logic                                                line_write_o,
  output logic                                                triangle_write_o,
  output logic [2:0]                                          color_depth_o,
  output logic                                                blending_enable_o,
  output logic                                                colorkey_enable_o,
  output logic [7:0]                                          a0_o,
  output logic [7:0]                                          a1_o,
  output logic [7:0]                                          a2_o,
  output logic [7:0]                                          global_alpha_o,
  output logic [GFX_DATA_BITS-1:0]                            colorkey_o,
  output logic [GFX_DATA_BITS-1:0]                            color0_o,
  output logic [GFX_DATA_BITS-1:0]                            target_base_o,
  output logic [GFX_POINT_BITS-1:0]                           target_size_x_o,
  output logic [GFX_POINT_BITS-1:0]                           target_size_y_o,
  output logic signed [GFX_POINT_BITS+GFX_SUBPIXEL_BITS-1:0]  dest_pixel_x_o,
  output logic signed [GFX_POINT_BITS+GFX_SUBPIXEL_BITS-1:0]  dest_pixel_y_o
);

  logic                         wr_en;
  logic [GFX_ADR_BITS-1:0]      wr_adr;
  logic [GFX_DATA_BITS-1:0]     wr_data;
  logic [GFX_ADR_BITS-1:0]      rd_adr;
  logic [GFX_DATA_BITS-1:0]     rd_data;
  logic [GFX_DATA_BITS-1:0]     status;
  logic                         fifo_full;
  logic                         fifo_valid;
  logic [GFX_ADR_BITS-1:0]      q_adr;
  logic [GFX_DATA_BITS-1:0]     q_data;
  logic [GFX_FIFO_CNT_BITS-1:0] fifo_count;
  logic                         deq;
  logic                         trigger;

  gfx_bus_slave bus_slave_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .adr_i         (adr_i),
    .dat_i         (dat_i),
    .sel_i         (sel_i),
    .we_i          (we_i),
    .stb_i         (stb_i),
    .cyc_i         (cyc_i),
    .writer_sint_i (writer_sint_i),
    .reader_sint_i (reader_sint_i),
    .fifo_full_i   (fifo_full),
    .rd_data_i     (rd_data),
    .status_i      (status),
    .dat_o         (dat_o),
    .ack_o         (ack_o),
    .err_o         (err_o),
    .inta_o        (inta_o),
    .wr_en_o       (wr_en),
    .wr_adr_o      (wr_adr),
    .wr_data_o     (wr_data),
    .rd_adr_o      (rd_adr)
  );

  gfx_cmd_fifo cmd_fifo_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .enq_i    (wr_en),
    .adr_i    (wr_adr),
    .data_i   (wr_data),
    .deq_i    (deq),
    .full_o   (fifo_full),
    .valid_o  (fifo_valid),
    .q_adr_o  (q_adr),
    .q_data_o (q_data),
    .count_o  (fifo_count)
  );

  // busy is seen outside only through the status word
  gfx_op_sequencer op_sequencer_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .valid_i        (fifo_valid),
    .trigger_i      (trigger),
    .pipeline_ack_i (pipeline_ack_i),
    .count_i        (fifo_count),
    .deq_o          (deq),
    .busy_o         (),
    .status_o       (status)
  );

  gfx_reg_file reg_file_i (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .wr_en_i           (deq),
    .wr_adr_i          (q_adr),
    .wr_data_i         (q_data),
    .rd_adr_i          (rd_adr),
    .rd_data_o         (rd_data),
    .trigger_o         (trigger),
    .rect_write_o      (rect_write_o),
    .line_write_o      (line_write_o),
    .triangle_write_o  (triangle_write_o),
    .color_depth_o     (color_depth_o),
    .blending_enable_o (blending_enable_o),
    .colorkey_enable_o (colorkey_enable_o),
    .a0_o              (a0_o),
    .a1_o              (a1_o),
    .a2_o              (a2_o),
    .global_alpha_o    (global_alpha_o),
    .colorkey_o        (colorkey_o),
    .color0_o          (color0_o),
    .target_base_o     (target_base_o),
    .target_size_x_o   (target_size_x_o),
    .target_size_y_o   (target_size_y_o),
    .dest_pixel_x_o    (dest_pixel_x_o),
    .dest_pixel_y_o    (dest_pixel_y_o)
  );

endmodule

`default_nettype wire

// File: tb_gfx_wbs.sv
// testbench for the gfx register front end
// bus accesses, triggers, queuing, back-pressure, errors and interrupt
`timescale 1ns/1ns
`default_nettype none

module tb_gfx_wbs import gfx_pkg::*;
();

  localparam int TIMEOUT = 200;

  logic               clk_i;
  logic               rst_i;
  logic [31:0]        adr_i;
  logic [31:0]        dat_i;
  logic [31:0]        dat_o;
  logic [3:0]         sel_i;
  logic               we_i;
  logic               stb_i;
  logic               cyc_i;
  logic               ack_o;
  logic               err_o;
  logic               inta_o;
  logic               writer_sint_i;
  logic               reader_sint_i;
  logic               pipeline_ack_i;
  logic               rect_write_o;
  logic               line_write_o;
  logic               triangle_write_o;
  logic [2:0]         color_depth_o;
  logic               blending_enable_o;
  logic               colorkey_enable_o;
  logic [7:0]         a0_o;
  logic [7:0]         a1_o;
  logic [7:0]         a2_o;
  logic [7:0]         global_alpha_o;
  logic [31:0]        colorkey_o;
  logic [31:0]        color0_o;
  logic [31:0]        target_base_o;
  logic [15:0]        target_size_x_o;
  logic [15:0]        target_size_y_o;
  logic signed [31:0] dest_pixel_x_o;
  logic signed [31:0] dest_pixel_y_o;

  logic [31:0] lcg_state;
  logic        sint_q;
  logic [2:0]  last_trig;
  int          trig_pulses = 0;

  gfx_wbs gfx_wbs_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic stop_failed();
    $display("Verification failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
      stop_failed();
    end
  endtask

  // one bus cycle, strobe held until ack or err
  task automatic bus_access(input logic we, input logic [7:0] off, input logic [31:0] wdata,
                            input logic [3:0] sel, output logic [31:0] rdata,
                            output logic got_err);
    int n;
    n = 0;
    @(posedge clk_i);
    adr_i <= {GFX_BASE_HI, 8'h00, off};
    dat_i <= wdata;
    sel_i <= sel;
    we_i  <= we;
    cyc_i <= 1'b1;
    stb_i <= 1'b1;
    @(negedge clk_i);
    while (!ack_o && !err_o)
    begin
      n++;
      if (n > TIMEOUT)
      begin
        $display("no ack_o or err_o on the bus within %0d cycles", TIMEOUT);
        stop_failed();
      end
      @(negedge clk_i);
    end
    rdata   = dat_o;
    got_err = err_o;
    @(posedge clk_i);
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
    we_i  <= 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] off, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    bus_access(1'b1, off, data, 4'hF, rd, err);
    check_eq("err_o on write", 32'(err), 32'h0);
  endtask

  task automatic read_reg(input logic [7:0] off, output logic [31:0] data);
    logic err;
    bus_access(1'b0, off, 32'h0, 4'hF, data, err);
    check_eq("err_o on read", 32'(err), 32'h0);
  endtask

  // poll status until the masked bits match
  task automatic wait_status(input logic [31:0] mask, input logic [31:0] exp, input string what);
    logic [31:0] st;
    int          n;
    n = 0;
    read_reg(GFX_STATUS, st);
    while ((st & mask) !== exp)
    begin
      n++;
      if (n > TIMEOUT)
      begin
        $display("status never showed %s", what);
        stop_failed();
      end
      read_reg(GFX_STATUS, st);
    end
  endtask

  task automatic pulse_pipeline_ack();
    @(posedge clk_i);
    pipeline_ack_i <= 1'b1;
    @(posedge clk_i);
    pipeline_ack_i <= 1'b0;
  endtask

  // register outputs gathered as 32-bit words
  function automatic logic [31:0] reg_output(input logic [7:0] off);
    case (off)
      GFX_ALPHA:         return {a0_o, a1_o, a2_o, global_alpha_o};
      GFX_COLORKEY:      return colorkey_o;
      GFX_TARGET_BASE:   return target_base_o;
      GFX_TARGET_SIZE_X: return {16'h0, target_size_x_o};
      GFX_TARGET_SIZE_Y: return {16'h0, target_size_y_o};
      GFX_DEST_PIXEL_X:  return dest_pixel_x_o;
      GFX_DEST_PIXEL_Y:  return dest_pixel_y_o;
      GFX_COLOR0:        return color0_o;
      default:           return 32'h0;
    endcase
  endfunction

  // interrupt inputs as seen at each edge
  always @(posedge clk_i)
  begin
    sint_q <= writer_sint_i | reader_sint_i;
  end

  always @(negedge clk_i)
  begin
    if (!rst_i)
    begin
      check_eq("inta_o", 32'(inta_o), 32'(sint_q));
      if (rect_write_o || line_write_o || triangle_write_o)
      begin
        trig_pulses++;
        last_trig = {triangle_write_o, line_write_o, rect_write_o};
      end
    end
  end

  trig_single: assert property (@(posedge clk_i) disable iff (rst_i)
    (rect_write_o || line_write_o || triangle_write_o)
    |=> !(rect_write_o || line_write_o || triangle_write_o))
  else
  begin
    $display("a trigger output stayed high for more than one cycle");
    stop_failed();
  end

  err_single: assert property (@(posedge clk_i) disable iff (rst_i)
    err_o |-> !ack_o ##1 !err_o)
  else
  begin
    $display("err_o came with ack_o or lasted more than one cycle");
    stop_failed();
  end

  initial
  begin
    logic [31:0] rd;
    logic [31:0] expv;
    logic [31:0] old_color;
    logic [31:0] ninth;
    logic        err;
    logic [31:0] vals [8];
    logic [7:0]  offs [8];
    string       names [8];
    int          base_pulses;
    lcg_state = 32'h1c96_d175;
    offs  = '{GFX_ALPHA, GFX_COLORKEY, GFX_TARGET_BASE, GFX_TARGET_SIZE_X,
              GFX_TARGET_SIZE_Y, GFX_DEST_PIXEL_X, GFX_DEST_PIXEL_Y, GFX_COLOR0};
    names = '{"alpha bytes", "colorkey_o", "target_base_o", "target_size_x_o",
              "target_size_y_o", "dest_pixel_x_o", "dest_pixel_y_o", "color0_o"};
    rst_i          <= 1'b1;
    adr_i          <= '0;
    dat_i          <= '0;
    sel_i          <= '0;
    we_i           <= 1'b0;
    stb_i          <= 1'b0;
    cyc_i          <= 1'b0;
    writer_sint_i  <= 1'b0;
    reader_sint_i  <= 1'b0;
    pipeline_ack_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);

    // reset values
    check_eq("a0_o", 32'(a0_o), 32'hFF);
    check_eq("a1_o", 32'(a1_o), 32'hFF);
    check_eq("a2_o", 32'(a2_o), 32'hFF);
    check_eq("global_alpha_o", 32'(global_alpha_o), 32'hFF);
    check_eq("trigger outputs", 32'({triangle_write_o, line_write_o, rect_write_o}), 32'h0);
    read_reg(GFX_ALPHA, rd);
    check_eq("alpha readback", rd, 32'hFFFF_FFFF);
    read_reg(GFX_CONTROL, rd);
    check_eq("control readback", rd, 32'h0);
    read_reg(GFX_STATUS, rd);
    check_eq("status readback", rd, 32'h0);

    // committed writes
    foreach (offs[i])
    begin
      vals[i] = lcg_next();
      write_reg(offs[i], vals[i]);
    end
    wait_status(32'hFFFF_FFFF, 32'h0, "an empty queue");
    foreach (offs[i])
    begin
      expv = vals[i];
      if (offs[i] == GFX_TARGET_SIZE_X || offs[i] == GFX_TARGET_SIZE_Y)
        expv = {16'h0, vals[i][15:0]};
      check_eq(names[i], reg_output(offs[i]), expv);
      read_reg(offs[i], rd);
      check_eq($sformatf("dat_o at 0x%02h", offs[i]), rd, vals[i]);
    end
    read_reg(8'h40, rd);
    check_eq("dat_o at 0x40", rd, 32'h0);

    // rect trigger, depth 5 with both enables
    base_pulses = trig_pulses;
    write_reg(GFX_CONTROL, 32'h0000_0135);
    wait_status(32'h1, 32'h1, "busy");
    check_eq("trigger pulse count", 32'(trig_pulses - base_pulses), 32'h1);
    check_eq("rect_write_o pulse", 32'(last_trig), 32'h1);
    check_eq("color_depth_o", 32'(color_depth_o), 32'h5);
    check_eq("blending_enable_o", 32'(blending_enable_o), 32'h1);
    check_eq("colorkey_enable_o", 32'(colorkey_enable_o), 32'h1);
    read_reg(GFX_CONTROL, rd);
    check_eq("control readback", rd, 32'h0000_0035);
    read_reg(GFX_STATUS, rd);
    check_eq("status busy bit", 32'(rd[0]), 32'h1);
    pulse_pipeline_ack();
    wait_status(32'hFFFF_FFFF, 32'h0, "idle after the pipeline acknowledge");

    // line trigger, colour 0 writes wait in the queue
    write_reg(GFX_CONTROL, 32'h0000_0235);
    wait_status(32'h1, 32'h1, "busy");
    check_eq("line_write_o pulse", 32'(last_trig), 32'h2);
    old_color = color0_o;
    for (int k = 0; k < 3; k++)
    begin
      vals[k] = lcg_next();
      write_reg(GFX_COLOR0, vals[k]);
    end
    check_eq("color0_o", color0_o, old_color);
    read_reg(GFX_STATUS, rd);
    check_eq("status", rd, {16'd3, 16'h0001});
    pulse_pipeline_ack();
    wait_status(32'hFFFF_FFFF, 32'h0, "an empty queue");
    check_eq("color0_o", color0_o, vals[2]);

    // triangle trigger, fill the queue and hold the ninth write
    write_reg(GFX_CONTROL, 32'h0000_0435);
    wait_status(32'h1, 32'h1, "busy");
    check_eq("triangle_write_o pulse", 32'(last_trig), 32'h4);
    for (int k = 0; k < 8; k++)
    begin
      write_reg(GFX_COLOR0, lcg_next());
    end
    read_reg(GFX_STATUS, rd);
    check_eq("status", rd, {16'd8, 16'h0001});
    ninth = lcg_next();
    fork
      write_reg(GFX_COLOR0, ninth);
      begin
        repeat (6)
        begin
          @(negedge clk_i);
          check_eq("ack_o while full", 32'(ack_o), 32'h0);
        end
        pulse_pipeline_ack();
      end
    join
    wait_status(32'hFFFF_FFFF, 32'h0, "an empty queue");
    check_eq("color0_o", color0_o, ninth);

    // partial selects give err_o only
    bus_access(1'b1, GFX_COLOR0, lcg_next(), 4'b0011, rd, err);
    check_eq("err_o on partial write", 32'(err), 32'h1);
    bus_access(1'b0, GFX_ALPHA, 32'h0, 4'b1000, rd, err);
    check_eq("err_o on partial read", 32'(err), 32'h1);
    wait_status(32'hFFFF_FFFF, 32'h0, "an empty queue");
    check_eq("color0_o", color0_o, ninth);
    read_reg(GFX_COLOR0, rd);
    check_eq("dat_o at 0x24", rd, ninth);

    // interrupt sources, checked every cycle by the monitor
    @(posedge clk_i);
    writer_sint_i <= 1'b1;
    repeat (3) @(posedge clk_i);
    writer_sint_i <= 1'b0;
    reader_sint_i <= 1'b1;
    repeat (3) @(posedge clk_i);
    writer_sint_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    writer_sint_i <= 1'b0;
    reader_sint_i <= 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: gfx_wbs.f
gfx_pkg.sv
gfx_bus_slave.sv
gfx_cmd_fifo.sv
gfx_op_sequencer.sv
gfx_reg_file.sv
gfx_wbs.sv
tb_gfx_wbs.sv

// File: run.sh
#!/bin/sh
# build and run the gfx_wbs testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns --top-module tb_gfx_wbs -f gfx_wbs.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vtb_gfx_wbs 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx 'Verification passed'; then
  exit 0
fi
echo "pass message not found in the simulation output"
exit 1
